// ==== hash_pkg.sv ====
`default_nettype none

package hash_pkg;

  // Key and payload widths
  localparam int KEY_W  = 32;
  localparam int DATA_W = 32;

  // Table geometry
  localparam int NUM_BANKS = 4;
  localparam int BANK_W    = 2;
  localparam int ROW_W     = 8;
  localparam int NUM_ROWS  = 256;

  // Bank read latency and commit depth
  localparam int MEM_DELAY  = 2;
  localparam int PIPE_DEPTH = MEM_DELAY + 1;

  // Pending update queue
  localparam int QSIZE  = 6;
  localparam int QCNT_W = 3;

  // Stored row is {valid, data, key}
  localparam int ENTRY_W = 1 + DATA_W + KEY_W;

  typedef logic [KEY_W-1:0]   key_t;
  typedef logic [DATA_W-1:0]  data_t;
  typedef logic [ROW_W-1:0]   row_t;
  typedef logic [BANK_W-1:0]  bank_t;
  typedef logic [ENTRY_W-1:0] entry_t;
  typedef logic [QCNT_W-1:0]  qidx_t;

  typedef enum logic {
    TBL_CLEAR,
    TBL_RUN
  } table_state_t;

endpackage

`default_nettype wire

// ==== bank_ram.sv ====
`default_nettype none

module bank_ram (
  input  logic             clk,
  input  logic             wr_en,
  input  hash_pkg::row_t   wr_row,
  input  hash_pkg::entry_t wr_data,
  input  logic             rd_en,
  input  hash_pkg::row_t   rd_row,
  output hash_pkg::entry_t rd_data
);
  import hash_pkg::*;

  entry_t mem [NUM_ROWS];
  entry_t rd_pipe [MEM_DELAY];

  always_ff @(posedge clk) begin
    if (wr_en) begin
      mem[wr_row] <= wr_data;
    end
  end

  // Read sees the array before a same-cycle write lands
  always_ff @(posedge clk) begin
    if (rd_en) begin
      rd_pipe[0] <= mem[rd_row];
    end
    for (int i = 1; i < MEM_DELAY; i++) begin
      rd_pipe[i] <= rd_pipe[i-1];
    end
  end

  assign rd_data = rd_pipe[MEM_DELAY-1];

endmodule

`default_nettype wire

// ==== bank_lookup_addr.sv ====
`default_nettype none

module bank_lookup_addr (
  input  logic                                      sr_en,
  input  hash_pkg::key_t                            sr_key,
  input  logic                                      iss_en,
  input  hash_pkg::key_t                            iss_key,
  output logic [hash_pkg::NUM_BANKS-1:0]            rd_en,
  output hash_pkg::row_t [hash_pkg::NUM_BANKS-1:0]  rd_row,
  output hash_pkg::row_t [hash_pkg::NUM_BANKS-1:0]  iss_rows
);
  import hash_pkg::*;

  key_t look_key;

  // Rotate left by 3 bits per bank, then fold the four bytes
  function automatic row_t hash_row(key_t key, int unsigned bank);
    key_t rot;
    rot = (key << (3 * bank)) | (key >> (KEY_W - 3 * bank));
    return rot[31:24] ^ rot[23:16] ^ rot[15:8] ^ rot[7:0];
  endfunction

  // Searches own the read ports whenever present
  assign look_key = sr_en ? sr_key : iss_key;

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      rd_en[b]    = sr_en | iss_en;
      rd_row[b]   = hash_row(look_key, b);
      iss_rows[b] = hash_row(iss_key, b);
    end
  end

  // The queue only issues in cycles without a search
  always_comb begin
    a_no_collide: assert final (!(sr_en && iss_en))
      else $error("search and update issue collide on the bank read ports");
  end

endmodule

`default_nettype wire

// ==== update_queue.sv ====
`default_nettype none

module update_queue (
  input  logic            clk,
  input  logic            rst,
  input  logic            ready,
  input  logic            up_en,
  input  hash_pkg::key_t  up_key,
  input  hash_pkg::data_t up_din,
  input  logic            up_del,
  input  logic            sr_en,
  input  hash_pkg::key_t  sr_key,
  input  logic            pop,
  output logic            iss_en,
  output hash_pkg::key_t  iss_key,
  output logic            qsr_hit,
  output logic            qsr_del,
  output hash_pkg::data_t qsr_dat,
  output hash_pkg::key_t  head_key,
  output hash_pkg::data_t head_dat,
  output logic            head_del,
  output logic            head_vld,
  output logic            up_bp
);
  import hash_pkg::*;

  logic [QSIZE-1:0] q_vld;
  logic [QSIZE-1:0] q_del;
  key_t             q_key [QSIZE];
  data_t            q_dat [QSIZE];
  qidx_t            q_cnt;
  qidx_t            iss_ptr;
  qidx_t            tail;

  logic [QSIZE-1:0] keep;
  logic [QSIZE-1:0] sh_vld;
  logic [QSIZE-1:0] sh_del;
  key_t             sh_key [QSIZE];
  data_t            sh_dat [QSIZE];

  // A new push supersedes older copies of its key
  always_comb begin
    for (int i = 0; i < QSIZE; i++) begin
      keep[i] = q_vld[i] & !(up_en && q_key[i] == up_key);
    end
  end

  // Entries move down by one on pop
  always_comb begin
    for (int i = 0; i < QSIZE; i++) begin
      sh_vld[i] = keep[i];
      sh_del[i] = q_del[i];
      sh_key[i] = q_key[i];
      sh_dat[i] = q_dat[i];
    end
    if (pop) begin
      for (int i = 0; i < QSIZE - 1; i++) begin
        sh_vld[i] = keep[i+1];
        sh_del[i] = q_del[i+1];
        sh_key[i] = q_key[i+1];
        sh_dat[i] = q_dat[i+1];
      end
      sh_vld[QSIZE-1] = 1'b0;
    end
  end

  assign tail = q_cnt - qidx_t'(pop);

  always_ff @(posedge clk) begin
    for (int i = 0; i < QSIZE; i++) begin
      if (up_en && qidx_t'(i) == tail) begin
        q_key[i] <= up_key;
        q_dat[i] <= up_din;
        q_del[i] <= up_del;
      end else begin
        q_key[i] <= sh_key[i];
        q_dat[i] <= sh_dat[i];
        q_del[i] <= sh_del[i];
      end
    end
  end

  always_ff @(posedge clk) begin
    if (rst) begin
      q_vld   <= '0;
      q_cnt   <= '0;
      iss_ptr <= '0;
    end else begin
      for (int i = 0; i < QSIZE; i++) begin
        q_vld[i] <= (up_en && qidx_t'(i) == tail) ? 1'b1 : sh_vld[i];
      end
      q_cnt   <= q_cnt + qidx_t'(up_en) - qidx_t'(pop);
      iss_ptr <= iss_ptr + qidx_t'(iss_en) - qidx_t'(pop);
    end
  end

  // Issue in order, only in cycles the search leaves free
  assign iss_en = ready & !sr_en & (iss_ptr < q_cnt);

  always_comb begin
    iss_key = '0;
    for (int i = 0; i < QSIZE; i++) begin
      if (qidx_t'(i) == iss_ptr) begin
        iss_key = q_key[i];
      end
    end
  end

  // At most one valid entry per key, so an OR merge is enough
  always_comb begin
    qsr_hit = 1'b0;
    qsr_del = 1'b0;
    qsr_dat = '0;
    for (int i = 0; i < QSIZE; i++) begin
      if (q_vld[i] && q_key[i] == sr_key) begin
        qsr_hit = 1'b1;
        qsr_del = qsr_del | q_del[i];
        qsr_dat = qsr_dat | q_dat[i];
      end
    end
  end

  assign head_key = q_key[0];
  assign head_dat = q_dat[0];
  assign head_del = q_del[0];
  assign head_vld = q_vld[0];
  assign up_bp    = q_cnt > qidx_t'(QSIZE - 2);

  a_no_overflow: assert property (@(posedge clk) disable iff (rst)
    up_en |-> q_cnt < qidx_t'(QSIZE));

  a_no_underflow: assert property (@(posedge clk) disable iff (rst)
    pop |-> q_cnt != '0);

endmodule

`default_nettype wire

// ==== update_engine.sv ====
`default_nettype none

module update_engine (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       iss_en,
  input  hash_pkg::row_t [hash_pkg::NUM_BANKS-1:0]   iss_rows,
  input  hash_pkg::entry_t [hash_pkg::NUM_BANKS-1:0] rd_data,
  input  hash_pkg::key_t                             head_key,
  input  hash_pkg::data_t                            head_dat,
  input  logic                                       head_del,
  input  logic                                       head_vld,
  output logic [hash_pkg::NUM_BANKS-1:0]             wr_en,
  output hash_pkg::row_t [hash_pkg::NUM_BANKS-1:0]   wr_row,
  output hash_pkg::entry_t [hash_pkg::NUM_BANKS-1:0] wr_data,
  output logic                                       pop,
  output logic                                       up_fail,
  output logic                                       ready
);
  import hash_pkg::*;

  table_state_t state;
  row_t         clr_row;

  logic [PIPE_DEPTH-1:0] p_vld;
  row_t [NUM_BANKS-1:0]  p_rows [PIPE_DEPTH];

  // Bank contents captured at the compare stage
  logic [NUM_BANKS-1:0] w_occ;
  logic [NUM_BANKS-1:0] w_blk;
  key_t [NUM_BANKS-1:0] w_key;
  logic [NUM_BANKS-1:0] blk;

  // Recent writes not yet visible to the compare stage
  logic [MEM_DELAY-1:0] hist_vld;
  bank_t                hist_bank [MEM_DELAY];
  row_t                 hist_row  [MEM_DELAY];

  logic  hit_m;
  logic  hit_f;
  bank_t bank_m;
  bank_t bank_f;
  logic  sel_hit;
  bank_t sel_bank;
  logic  cur_wr;

  always_ff @(posedge clk) begin
    if (rst) begin
      state   <= TBL_CLEAR;
      clr_row <= '0;
    end else if (state == TBL_CLEAR) begin
      if (clr_row == row_t'(NUM_ROWS - 1)) begin
        state <= TBL_RUN;
      end
      clr_row <= clr_row + 1'b1;
    end
  end

  assign ready = (state == TBL_RUN);

  always_ff @(posedge clk) begin
    if (rst) begin
      p_vld    <= '0;
      hist_vld <= '0;
    end else begin
      p_vld    <= {p_vld[PIPE_DEPTH-2:0], iss_en};
      hist_vld <= {hist_vld[MEM_DELAY-2:0], cur_wr};
    end
  end

  always_ff @(posedge clk) begin
    p_rows[0]    <= iss_rows;
    hist_bank[0] <= sel_bank;
    hist_row[0]  <= p_rows[PIPE_DEPTH-1][sel_bank];
    for (int i = 1; i < PIPE_DEPTH; i++) begin
      p_rows[i] <= p_rows[i-1];
    end
    for (int i = 1; i < MEM_DELAY; i++) begin
      hist_bank[i] <= hist_bank[i-1];
      hist_row[i]  <= hist_row[i-1];
    end
    for (int b = 0; b < NUM_BANKS; b++) begin
      w_occ[b] <= rd_data[b][KEY_W+DATA_W];
      w_key[b] <= rd_data[b][KEY_W-1:0];
    end
    w_blk <= blk;
  end

  // Lookahead blocks a row being written right now or just before
  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      blk[b] = cur_wr && sel_bank == bank_t'(b) &&
               p_rows[PIPE_DEPTH-1][b] == p_rows[MEM_DELAY-1][b];
      for (int i = 0; i < MEM_DELAY; i++) begin
        blk[b] = blk[b] | (hist_vld[i] && hist_bank[i] == bank_t'(b) &&
                           hist_row[i] == p_rows[MEM_DELAY-1][b]);
      end
    end
  end

  // Lowest bank wins, so scan downwards
  always_comb begin
    hit_m  = 1'b0;
    hit_f  = 1'b0;
    bank_m = '0;
    bank_f = '0;
    for (int b = NUM_BANKS - 1; b >= 0; b--) begin
      if (!w_blk[b] && w_occ[b] && w_key[b] == head_key) begin
        hit_m  = 1'b1;
        bank_m = bank_t'(b);
      end
      if (!w_blk[b] && !w_occ[b]) begin
        hit_f  = 1'b1;
        bank_f = bank_t'(b);
      end
    end
  end

  assign sel_hit  = hit_m | hit_f;
  assign sel_bank = hit_m ? bank_m : bank_f;

  // Superseded entries leave the queue without a write
  assign pop     = p_vld[PIPE_DEPTH-1];
  assign cur_wr  = pop & head_vld & sel_hit;
  assign up_fail = pop & head_vld & !sel_hit;

  always_comb begin
    for (int b = 0; b < NUM_BANKS; b++) begin
      if (state == TBL_CLEAR) begin
        wr_en[b]   = 1'b1;
        wr_row[b]  = clr_row;
        wr_data[b] = '0;
      end else begin
        wr_en[b]   = cur_wr && sel_bank == bank_t'(b);
        wr_row[b]  = p_rows[PIPE_DEPTH-1][b];
        wr_data[b] = {!head_del, head_dat, head_key};
      end
    end
  end

  // A row written in TBL_RUN stays untouched until later reads can see it
  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_rewrite_chk
    a_no_rewrite: assert property (@(posedge clk) disable iff (rst)
      (state == TBL_RUN && wr_en[b]) |->
        !($past(wr_en[b], 1) && $past(wr_row[b], 1) == wr_row[b]) &&
        !($past(wr_en[b], 2) && $past(wr_row[b], 2) == wr_row[b]) &&
        !($past(wr_en[b], 3) && $past(wr_row[b], 3) == wr_row[b]));
  end

endmodule

`default_nettype wire

// ==== search_path.sv ====
`default_nettype none

module search_path (
  input  logic                                       clk,
  input  logic                                       rst,
  input  logic                                       ready,
  input  logic                                       sr_en,
  input  hash_pkg::key_t                             sr_key,
  input  logic                                       qsr_hit,
  input  logic                                       qsr_del,
  input  hash_pkg::data_t                            qsr_dat,
  input  hash_pkg::entry_t [hash_pkg::NUM_BANKS-1:0] rd_data,
  output logic                                       sr_vld,
  output logic                                       sr_match,
  output hash_pkg::data_t                            sr_dout
);
  import hash_pkg::*;

  logic [MEM_DELAY-1:0] d_en;
  logic [MEM_DELAY-1:0] d_hit;
  logic [MEM_DELAY-1:0] d_del;
  key_t                 d_key [MEM_DELAY];
  data_t                d_dat [MEM_DELAY];

  logic  bnk_hit;
  data_t bnk_dat;

  always_ff @(posedge clk) begin
    if (rst) begin
      d_en  <= '0;
      d_hit <= '0;
    end else begin
      d_en  <= {d_en[MEM_DELAY-2:0], sr_en & ready};
      d_hit <= {d_hit[MEM_DELAY-2:0], qsr_hit};
    end
  end

  // Key and queue result ride along with the bank read
  always_ff @(posedge clk) begin
    d_del    <= {d_del[MEM_DELAY-2:0], qsr_del};
    d_key[0] <= sr_key;
    d_dat[0] <= qsr_dat;
    for (int i = 1; i < MEM_DELAY; i++) begin
      d_key[i] <= d_key[i-1];
      d_dat[i] <= d_dat[i-1];
    end
  end

  always_comb begin
    bnk_hit = 1'b0;
    bnk_dat = '0;
    for (int b = NUM_BANKS - 1; b >= 0; b--) begin
      if (rd_data[b][KEY_W+DATA_W] && rd_data[b][KEY_W-1:0] == d_key[MEM_DELAY-1]) begin
        bnk_hit = 1'b1;
        bnk_dat = rd_data[b][KEY_W +: DATA_W];
      end
    end
  end

  // Pending update in the queue is newer than any bank copy
  assign sr_vld   = d_en[MEM_DELAY-1];
  assign sr_match = sr_vld & (d_hit[MEM_DELAY-1] ? !d_del[MEM_DELAY-1] : bnk_hit);
  assign sr_dout  = d_hit[MEM_DELAY-1] ? d_dat[MEM_DELAY-1] : bnk_dat;

endmodule

`default_nettype wire

// ==== hash_table_top.sv ====
`default_nettype none

module hash_table_top (
  input  logic            clk,
  input  logic            rst,
  input  logic            sr_en,
  input  hash_pkg::key_t  sr_key,
  input  logic            up_en,
  input  hash_pkg::key_t  up_key,
  input  hash_pkg::data_t up_din,
  input  logic            up_del,
  output logic            ready,
  output logic            sr_vld,
  output logic            sr_match,
  output hash_pkg::data_t sr_dout,
  output logic            up_bp,
  output logic            up_fail
);
  import hash_pkg::*;

  logic   iss_en;
  key_t   iss_key;
  logic   pop;
  logic   qsr_hit;
  logic   qsr_del;
  data_t  qsr_dat;
  key_t   head_key;
  data_t  head_dat;
  logic   head_del;
  logic   head_vld;

  logic [NUM_BANKS-1:0]   rd_en;
  row_t [NUM_BANKS-1:0]   rd_row;
  row_t [NUM_BANKS-1:0]   iss_rows;
  entry_t [NUM_BANKS-1:0] rd_data;
  logic [NUM_BANKS-1:0]   wr_en;
  row_t [NUM_BANKS-1:0]   wr_row;
  entry_t [NUM_BANKS-1:0] wr_data;

  update_queue update_queue_i (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .up_en    (up_en),
    .up_key   (up_key),
    .up_din   (up_din),
    .up_del   (up_del),
    .sr_en    (sr_en),
    .sr_key   (sr_key),
    .pop      (pop),
    .iss_en   (iss_en),
    .iss_key  (iss_key),
    .qsr_hit  (qsr_hit),
    .qsr_del  (qsr_del),
    .qsr_dat  (qsr_dat),
    .head_key (head_key),
    .head_dat (head_dat),
    .head_del (head_del),
    .head_vld (head_vld),
    .up_bp    (up_bp)
  );

  bank_lookup_addr bank_lookup_addr_i (
    .sr_en    (sr_en),
    .sr_key   (sr_key),
    .iss_en   (iss_en),
    .iss_key  (iss_key),
    .rd_en    (rd_en),
    .rd_row   (rd_row),
    .iss_rows (iss_rows)
  );

  for (genvar b = 0; b < NUM_BANKS; b++) begin : g_bank
    bank_ram bank_ram_i (
      .clk     (clk),
      .wr_en   (wr_en[b]),
      .wr_row  (wr_row[b]),
      .wr_data (wr_data[b]),
      .rd_en   (rd_en[b]),
      .rd_row  (rd_row[b]),
      .rd_data (rd_data[b])
    );
  end

  update_engine update_engine_i (
    .clk      (clk),
    .rst      (rst),
    .iss_en   (iss_en),
    .iss_rows (iss_rows),
    .rd_data  (rd_data),
    .head_key (head_key),
    .head_dat (head_dat),
    .head_del (head_del),
    .head_vld (head_vld),
    .wr_en    (wr_en),
    .wr_row   (wr_row),
    .wr_data  (wr_data),
    .pop      (pop),
    .up_fail  (up_fail),
    .ready    (ready)
  );

  search_path search_path_i (
    .clk      (clk),
    .rst      (rst),
    .ready    (ready),
    .sr_en    (sr_en),
    .sr_key   (sr_key),
    .qsr_hit  (qsr_hit),
    .qsr_del  (qsr_del),
    .qsr_dat  (qsr_dat),
    .rd_data  (rd_data),
    .sr_vld   (sr_vld),
    .sr_match (sr_match),
    .sr_dout  (sr_dout)
  );

endmodule

`default_nettype wire

// ==== tb_hash_table.sv ====
`default_nettype none

module tb_hash_table;
  import hash_pkg::*;

  localparam int POOL_N = 48;

  logic  clk;
  logic  rst;
  logic  sr_en;
  key_t  sr_key;
  logic  up_en;
  key_t  up_key;
  data_t up_din;
  logic  up_del;
  logic  ready;
  logic  sr_vld;
  logic  sr_match;
  data_t sr_dout;
  logic  up_bp;
  logic  up_fail;

  // Reference table, one array set per bank
  logic  m_vld [NUM_BANKS][NUM_ROWS];
  key_t  m_key [NUM_BANKS][NUM_ROWS];
  data_t m_dat [NUM_BANKS][NUM_ROWS];

  // Updates accepted since the last drain, oldest first
  key_t  pend_key [$];
  data_t pend_dat [$];
  logic  pend_del [$];

  key_t        pool [POOL_N];
  logic [1:0]  exp_vld;
  logic        exp_match [2];
  data_t       exp_dat [2];
  logic [31:0] rng;
  logic        bp_track;
  int          err_cnt;
  int          fail_seen;
  int          fail_exp;

  hash_table_top hash_table_top_i (
    .clk      (clk),
    .rst      (rst),
    .sr_en    (sr_en),
    .sr_key   (sr_key),
    .up_en    (up_en),
    .up_key   (up_key),
    .up_din   (up_din),
    .up_del   (up_del),
    .ready    (ready),
    .sr_vld   (sr_vld),
    .sr_match (sr_match),
    .sr_dout  (sr_dout),
    .up_bp    (up_bp),
    .up_fail  (up_fail)
  );

  initial clk = 1'b0;
  always #50 clk = ~clk;

  function automatic logic [31:0] next_rand();
    rng = rng ^ (rng << 13);
    rng = rng ^ (rng >> 17);
    rng = rng ^ (rng << 5);
    return rng;
  endfunction

  // Rotate left by 3 bits per bank, fold the bytes
  function automatic row_t row_of(key_t k, int b);
    logic [63:0] dbl;
    logic [31:0] r;
    dbl = {k, k} << (3 * b);
    r = dbl[63:32];
    return r[31:24] ^ r[23:16] ^ r[15:8] ^ r[7:0];
  endfunction

  function automatic logic is_pending(key_t k);
    for (int i = 0; i < pend_key.size(); i++) begin
      if (pend_key[i] == k) begin
        return 1'b1;
      end
    end
    return 1'b0;
  endfunction

  function automatic key_t fresh_key();
    int start;
    start = next_rand() % POOL_N;
    for (int i = 0; i < POOL_N; i++) begin
      if (!is_pending(pool[(start + i) % POOL_N])) begin
        return pool[(start + i) % POOL_N];
      end
    end
    return pool[start];
  endfunction

  // Latest accepted update wins over the committed table
  task automatic expect_search(input key_t k, output logic hit, output data_t d);
    logic found;
    row_t r;
    found = 1'b0;
    hit = 1'b0;
    d = '0;
    for (int i = 0; i < pend_key.size(); i++) begin
      if (pend_key[i] == k) begin
        found = 1'b1;
        hit = !pend_del[i];
        d = pend_dat[i];
      end
    end
    for (int b = NUM_BANKS - 1; b >= 0; b--) begin
      r = row_of(k, b);
      if (!found && m_vld[b][r] && m_key[b][r] == k) begin
        hit = 1'b1;
        d = m_dat[b][r];
      end
    end
  endtask

  // Commit in order to the first bank holding the key, else the first free bank
  task automatic commit_pending();
    row_t r;
    int   sel_m;
    int   sel_f;
    int   sel;
    for (int i = 0; i < pend_key.size(); i++) begin
      sel_m = -1;
      sel_f = -1;
      for (int b = NUM_BANKS - 1; b >= 0; b--) begin
        r = row_of(pend_key[i], b);
        if (!m_vld[b][r]) sel_f = b;
        if (m_vld[b][r] && m_key[b][r] == pend_key[i]) sel_m = b;
      end
      sel = (sel_m >= 0) ? sel_m : sel_f;
      if (sel < 0) begin
        fail_exp++;
      end else begin
        r = row_of(pend_key[i], sel);
        m_vld[sel][r] = !pend_del[i];
        m_key[sel][r] = pend_key[i];
        m_dat[sel][r] = pend_dat[i];
      end
    end
    pend_key.delete();
    pend_dat.delete();
    pend_del.delete();
  endtask

  task automatic check_outputs();
    if (sr_vld !== exp_vld[1]) begin
      err_cnt++;
      $display("Fail at time %0t: sr_vld is %b, expected %b", $time, sr_vld, exp_vld[1]);
    end else if (exp_vld[1] && sr_match !== exp_match[1]) begin
      err_cnt++;
      $display("Fail at time %0t: sr_match is %b, expected %b", $time, sr_match,
               exp_match[1]);
    end else if (exp_vld[1] && exp_match[1] && sr_dout !== exp_dat[1]) begin
      err_cnt++;
      $display("Fail at time %0t: sr_dout is %h, expected %h", $time, sr_dout, exp_dat[1]);
    end
    if (bp_track && up_bp !== (pend_key.size() > QSIZE - 2)) begin
      err_cnt++;
      $display("Fail at time %0t: up_bp is %b with %0d queued updates", $time, up_bp,
               pend_key.size());
    end
    if (up_fail === 1'b1) fail_seen++;
  endtask

  // Check outputs, then drive the next inputs, once per clock
  task automatic step(input logic s_en, input key_t s_k, input logic u_want,
                      input key_t u_k, input data_t u_d, input logic u_dl,
                      output logic taken);
    logic  hit;
    data_t d;
    @(negedge clk);
    check_outputs();
    exp_vld[1] = exp_vld[0];
    exp_match[1] = exp_match[0];
    exp_dat[1] = exp_dat[0];
    hit = 1'b0;
    d = '0;
    if (s_en) expect_search(s_k, hit, d);
    taken = u_want && ready && !up_bp;
    sr_en = s_en;
    sr_key = s_k;
    up_en = taken;
    up_key = u_k;
    up_din = u_d;
    up_del = u_dl;
    exp_vld[0] = s_en;
    exp_match[0] = hit;
    exp_dat[0] = d;
    if (taken) begin
      pend_key.push_back(u_k);
      pend_dat.push_back(u_d);
      pend_del.push_back(u_dl);
    end
  endtask

  task automatic idle(int n);
    logic t;
    repeat (n) step(1'b0, '0, 1'b0, '0, '0, 1'b0, t);
  endtask

  task automatic search_key(key_t k);
    logic t;
    step(1'b1, k, 1'b0, '0, '0, 1'b0, t);
  endtask

  task automatic search_all();
    for (int i = 0; i < POOL_N; i++) begin
      search_key(pool[i]);
    end
    idle(2);
  endtask

  task automatic abort_run(string msg);
    $display("%s", msg);
    $display("TESTBENCH FAILED");
    $finish;
  endtask

  task automatic wait_ready();
    int n;
    n = 0;
    while (ready !== 1'b1 && n < 400) begin
      idle(1);
      n++;
    end
    if (ready !== 1'b1) abort_run("Timeout: ready never came up after reset");
  endtask

  // Queue below back-pressure, then enough idle cycles to commit the rest
  task automatic drain();
    int n;
    n = 0;
    while (up_bp !== 1'b0 && n < 50) begin
      idle(1);
      n++;
    end
    if (up_bp !== 1'b0) abort_run("Timeout: update queue did not drain");
    idle(10);
    commit_pending();
  endtask

  initial begin
    logic        t;
    logic        hit;
    logic        last_ins;
    key_t        last_key;
    key_t        k;
    data_t       d;
    logic [31:0] r;
    int          n;
    int          dels;

    rng = 32'h23fe46d4;
    rst = 1'b1;
    sr_en = 1'b0;
    sr_key = '0;
    up_en = 1'b0;
    up_key = '0;
    up_din = '0;
    up_del = 1'b0;
    exp_vld = '0;
    exp_match[0] = 1'b0;
    exp_match[1] = 1'b0;
    exp_dat[0] = '0;
    exp_dat[1] = '0;
    bp_track = 1'b0;
    err_cnt = 0;
    fail_seen = 0;
    fail_exp = 0;
    for (int b = 0; b < NUM_BANKS; b++) begin
      for (int i = 0; i < NUM_ROWS; i++) begin
        m_vld[b][i] = 1'b0;
        m_key[b][i] = '0;
        m_dat[b][i] = '0;
      end
    end
    // Low bits make every pool key distinct
    // Keys of four equal bytes land on row 0 in every bank and overflow it
    for (int i = 0; i < POOL_N; i++) begin
      r = next_rand();
      if (i < 8) begin
        pool[i] = {4{8'(i)}};
      end else begin
        pool[i] = {r[31:6], 6'(i)};
      end
    end

    repeat (2) @(negedge clk);
    rst = 1'b0;
    wait_ready();

    // Empty table after reset
    for (int i = 0; i < 16; i++) begin
      search_key(pool[next_rand() % POOL_N]);
    end
    idle(2);

    // Insert bursts, each insert searched in the next cycle
    for (int round = 0; round < 3; round++) begin
      n = 0;
      last_ins = 1'b0;
      last_key = '0;
      for (int c = 0; c < 200 && n < 20; c++) begin
        k = fresh_key();
        d = next_rand();
        r = next_rand();
        step(last_ins, last_key, r[0], k, d, 1'b0, t);
        last_ins = t;
        last_key = k;
        if (t) n++;
      end
      if (last_ins) search_key(last_key);
      drain();
      search_all();
    end

    // Deletes of present keys, one at a time
    dels = 0;
    for (int i = 0; i < POOL_N && dels < 6; i++) begin
      expect_search(pool[i], hit, d);
      if (hit) begin
        step(1'b0, '0, 1'b1, pool[i], next_rand(), 1'b1, t);
        search_key(pool[i]);
        drain();
        search_key(pool[i]);
        idle(2);
        dels++;
      end
    end

    // Searches every cycle hold off commits, so the queue fills
    for (int round = 0; round < 3; round++) begin
      bp_track = 1'b1;
      for (int c = 0; c < 30; c++) begin
        k = fresh_key();
        d = next_rand();
        r = next_rand();
        step(1'b1, pool[next_rand() % POOL_N], r[1:0] != 2'b00, k, d, 1'b0, t);
      end
      bp_track = 1'b0;
      drain();
      search_all();
    end

    idle(3);
    if (fail_seen != fail_exp) begin
      err_cnt++;
      $display("Fail at time %0t: %0d up_fail pulses, expected %0d", $time, fail_seen,
               fail_exp);
    end
    $display("Summary: %0d errors, %0d up_fail pulses seen, %0d expected", err_cnt,
             fail_seen, fail_exp);
    if (err_cnt == 0) begin
      $display("TESTBENCH PASSED");
    end else begin
      $display("TESTBENCH FAILED");
    end
    $finish;
  end

endmodule

`default_nettype wire

// ==== list.f ====
hash_pkg.sv
bank_ram.sv
bank_lookup_addr.sv
update_queue.sv
update_engine.sv
search_path.sv
hash_table_top.sv
tb_hash_table.sv

// ==== run.sh ====
#!/bin/sh
set -e

cd "$(dirname "$0")"
rm -rf obj_dir
verilator --binary --timing --assert -Wno-fatal --top-module tb_hash_table \
  -f list.f -o tb_hash_table
./obj_dir/tb_hash_table > sim.log 2>&1 || true
cat sim.log
if grep -qx "TESTBENCH PASSED" sim.log; then
  exit 0
fi
exit 1
